//--- Makefile
TOP := rob_tb
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/rob_tb.sv
`timescale 1ns/100ps
`default_nettype none

module rob_tb;

	localparam int RESET_CYCLES = 8;
	localparam int RAND_STEPS = 80;
	// budget per test in cycles, the random test plus its drain dominates.
	localparam int TEST_CYCLES = 30 + 30 + 20 + 20 + RAND_STEPS + 40;
	localparam int TIMEOUT_CYCLES = 2 * TEST_CYCLES + 4 * RESET_CYCLES;
	localparam logic [31:0] REDIRECT_TARGET = 32'h0000_8000;

	logic clock;
	logic arst_n;
	logic [rob_pkg::LANES-1:0] disp_valid;
	uop_pkg::arch_reg_t [rob_pkg::LANES-1:0] disp_arch_reg;
	uop_pkg::phys_tag_t [rob_pkg::LANES-1:0] disp_phys_tag;
	uop_pkg::pc_t [rob_pkg::LANES-1:0] disp_pc;
	rob_pkg::rob_index_t [rob_pkg::LANES-1:0] disp_index;
	logic [rob_pkg::LANES-1:0] cmp_valid;
	rob_pkg::rob_index_t [rob_pkg::LANES-1:0] cmp_index;
	logic [rob_pkg::LANES-1:0] cmp_redirect;
	uop_pkg::pc_t [rob_pkg::LANES-1:0] cmp_target;
	logic [rob_pkg::LANES-1:0] ret_valid;
	uop_pkg::arch_reg_t [rob_pkg::LANES-1:0] ret_arch_reg;
	uop_pkg::phys_tag_t [rob_pkg::LANES-1:0] ret_phys_tag;
	uop_pkg::pc_t [rob_pkg::LANES-1:0] ret_pc;
	logic [rob_pkg::LANES-1:0] freed_valid;
	uop_pkg::phys_tag_t [rob_pkg::LANES-1:0] freed_tag;
	rob_pkg::lane_count_t credit_return;
	logic flush;
	uop_pkg::pc_t redirect_pc;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	uop_pkg::arch_reg_t m_reg [rob_pkg::ROB_DEPTH];
	uop_pkg::phys_tag_t m_tag [rob_pkg::ROB_DEPTH];
	uop_pkg::pc_t m_pc [rob_pkg::ROB_DEPTH];
	logic m_done [rob_pkg::ROB_DEPTH];
	logic m_redir [rob_pkg::ROB_DEPTH];
	uop_pkg::pc_t m_target [rob_pkg::ROB_DEPTH];
	uop_pkg::phys_tag_t exp_map [uop_pkg::ARCH_REGS];
	// entries in program order, oldest first.
	rob_pkg::rob_index_t order [$];
	// dispatched entries that have not been completed yet.
	rob_pkg::rob_index_t issued [$];
	uop_pkg::phys_tag_t freed_log [$];
	rob_pkg::rob_index_t model_tail;
	logic flush_due;
	uop_pkg::pc_t flush_pc;
	int credits;
	int errors;
	int checks;
	int retired;
	int flush_seen;
	int seq;
	logic [15:0] lfsr;

	rob_top u_dut (
		.clock(clock),
		.arst_n(arst_n),
		.disp_valid(disp_valid),
		.disp_arch_reg(disp_arch_reg),
		.disp_phys_tag(disp_phys_tag),
		.disp_pc(disp_pc),
		.disp_index(disp_index),
		.cmp_valid(cmp_valid),
		.cmp_index(cmp_index),
		.cmp_redirect(cmp_redirect),
		.cmp_target(cmp_target),
		.ret_valid(ret_valid),
		.ret_arch_reg(ret_arch_reg),
		.ret_phys_tag(ret_phys_tag),
		.ret_pc(ret_pc),
		.freed_valid(freed_valid),
		.freed_tag(freed_tag),
		.credit_return(credit_return),
		.flush(flush),
		.redirect_pc(redirect_pc)
	);

	initial begin
		clock = 1'b0;
		forever begin
			#10 clock = ~clock;
		end
	end

	initial begin : watchdog
		int count;

		count = 0;
		while (count < TIMEOUT_CYCLES) begin
			@(posedge clock);
			count++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	// 16-bit Galois LFSR with taps 16, 14, 13 and 11.
	function automatic int unsigned take_bits(input int n);
		int unsigned value;

		value = 0;
		for (int i = 0; i < n; i++) begin
			value = (value << 1) | 32'(lfsr[0]);
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
		end
		return value;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic clear_inputs();
		disp_valid = '0;
		disp_arch_reg = '0;
		disp_phys_tag = '0;
		disp_pc = '0;
		cmp_valid = '0;
		cmp_index = '0;
		cmp_redirect = '0;
		cmp_target = '0;
	endtask

	task automatic apply_reset();
		arst_n = 1'b0;
		clear_inputs();
		order.delete();
		issued.delete();
		freed_log.delete();
		for (int e = 0; e < rob_pkg::ROB_DEPTH; e++) begin
			m_done[e] = 1'b0;
			m_redir[e] = 1'b0;
		end
		// the map comes out of reset as the identity.
		for (int r = 0; r < uop_pkg::ARCH_REGS; r++) begin
			exp_map[r] = uop_pkg::phys_tag_t'(r);
		end
		model_tail = '0;
		flush_due = 1'b0;
		flush_pc = '0;
		credits = rob_pkg::ROB_DEPTH;
		repeat (RESET_CYCLES) @(posedge clock);
		#2;
		arst_n = 1'b1;
	endtask

	task automatic put_uop(input int lane, input uop_pkg::arch_reg_t reg_num,
		input uop_pkg::phys_tag_t tag);
		if (credits == 0) begin
			errors++;
			$display("dispatch attempted at %0t with no credit left", $time);
		end
		credits--;
		disp_valid[lane] = 1'b1;
		disp_arch_reg[lane] = reg_num;
		disp_phys_tag[lane] = tag;
		disp_pc[lane] = 32'h1000 + 32'(seq) * 4;
		seq++;
		issued.push_back(model_tail + rob_pkg::rob_index_t'(lane));
	endtask

	task automatic dispatch_group(input int count, input logic rnd);
		for (int lane = 0; lane < count; lane++) begin
			if (rnd) begin
				put_uop(lane, uop_pkg::arch_reg_t'(take_bits(3)),
					uop_pkg::phys_tag_t'(take_bits(6)));
			end else begin
				put_uop(lane, uop_pkg::arch_reg_t'(seq * 7), uop_pkg::phys_tag_t'(seq + 33));
			end
		end
	endtask

	task automatic put_cmp(input int lane, input rob_pkg::rob_index_t index,
		input logic redirect, input uop_pkg::pc_t target);
		cmp_valid[lane] = 1'b1;
		cmp_index[lane] = index;
		cmp_redirect[lane] = redirect;
		cmp_target[lane] = target;
	endtask

	// checks one cycle against the model, then lets the edge happen.
	task automatic cycle();
		int n;
		logic redir;
		rob_pkg::rob_index_t e;
		rob_pkg::rob_index_t idx;

		@(negedge clock);
		n = 0;
		redir = 1'b0;
		e = '0;
		while (n < rob_pkg::LANES && n < order.size() && !redir && m_done[order[n]]) begin
			redir = m_redir[order[n]];
			n++;
		end
		check("flush", 32'(flush), 32'(flush_due));
		if (flush) begin
			flush_seen++;
		end
		if (flush_due) begin
			check("redirect_pc", redirect_pc, flush_pc);
		end
		flush_due = 1'b0;
		check("credit_return", 32'(credit_return), 32'(n));
		for (int i = 0; i < rob_pkg::LANES; i++) begin
			check($sformatf("ret_valid lane %0d", i), 32'(ret_valid[i]), 32'(i < n));
			check($sformatf("freed_valid lane %0d", i), 32'(freed_valid[i]), 32'(i < n));
			if (i < n) begin
				e = order[i];
				check($sformatf("ret_pc lane %0d", i), ret_pc[i], m_pc[e]);
				check($sformatf("ret_arch_reg lane %0d", i), 32'(ret_arch_reg[i]), 32'(m_reg[e]));
				check($sformatf("ret_phys_tag lane %0d", i), 32'(ret_phys_tag[i]), 32'(m_tag[e]));
				check($sformatf("freed_tag lane %0d", i), 32'(freed_tag[i]),
					32'(exp_map[m_reg[e]]));
				freed_log.push_back(freed_tag[i]);
				exp_map[m_reg[e]] = m_tag[e];
				m_done[e] = 1'b0;
			end
		end
		repeat (n) void'(order.pop_front());
		retired += $countones(ret_valid);
		credits += int'(credit_return);
		if (redir) begin
			// all younger work and any dispatch of this cycle is dropped.
			flush_due = 1'b1;
			flush_pc = m_target[e];
			order.delete();
			model_tail = '0;
		end else begin
			for (int i = 0; i < rob_pkg::LANES; i++) begin
				if (disp_valid[i]) begin
					idx = model_tail + rob_pkg::rob_index_t'(i);
					check($sformatf("disp_index lane %0d", i), 32'(disp_index[i]), 32'(idx));
					m_reg[idx] = disp_arch_reg[i];
					m_tag[idx] = disp_phys_tag[i];
					m_pc[idx] = disp_pc[i];
					m_done[idx] = 1'b0;
					m_redir[idx] = 1'b0;
					order.push_back(idx);
				end
			end
			model_tail = model_tail + rob_pkg::rob_index_t'($countones(disp_valid));
			for (int i = 0; i < rob_pkg::LANES; i++) begin
				if (cmp_valid[i]) begin
					m_done[cmp_index[i]] = 1'b1;
					m_redir[cmp_index[i]] = cmp_redirect[i];
					m_target[cmp_index[i]] = cmp_target[i];
				end
			end
		end
		@(posedge clock);
		#2;
		if (flush) begin
			credits = rob_pkg::ROB_DEPTH;
		end
		clear_inputs();
	endtask

	task automatic complete_issued();
		while (issued.size() > 0) begin
			for (int lane = 0; lane < rob_pkg::LANES && issued.size() > 0; lane++) begin
				put_cmp(lane, issued.pop_front(), 1'b0, 32'h0);
			end
			cycle();
		end
	endtask

	task automatic drain();
		while (order.size() > 0) begin
			cycle();
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic test_in_order();
		int base;

		base = retired;
		issued.delete();
		dispatch_group(3, 1'b0);
		cycle();
		dispatch_group(3, 1'b0);
		cycle();
		dispatch_group(2, 1'b0);
		cycle();
		// youngest first, so nothing may leave before the oldest is done.
		for (int i = 7; i >= 0; i--) begin
			put_cmp(0, issued[i], 1'b0, 32'h0);
			cycle();
		end
		issued.delete();
		drain();
		check("in-order retired count", 32'(retired - base), 32'd8);
	endtask

	task automatic test_credits();
		issued.delete();
		while (credits > 0) begin
			dispatch_group((credits < 3) ? credits : 3, 1'b0);
			cycle();
		end
		// a full buffer has its tail wrapped round onto the head.
		check("tail when out of credits", 32'(disp_index[0]), 32'(order[0]));
		complete_issued();
		drain();
		check("credits after drain", 32'(credits), 32'(rob_pkg::ROB_DEPTH));
	endtask

	task automatic test_freed_tags();
		apply_reset();
		put_uop(0, 5'd5, 6'd40);
		put_uop(1, 5'd5, 6'd41);
		put_uop(2, 5'd9, 6'd42);
		cycle();
		complete_issued();
		drain();
		check("freed tag count", 32'(freed_log.size()), 32'd3);
		check("freed tag of first write to r5", 32'(freed_log[0]), 32'd5);
		check("freed tag of second write to r5", 32'(freed_log[1]), 32'd40);
		check("freed tag of first write to r9", 32'(freed_log[2]), 32'd9);
	endtask

	task automatic test_redirect_flush();
		int base;
		int flush_base;

		base = retired;
		flush_base = flush_seen;
		issued.delete();
		dispatch_group(3, 1'b0);
		cycle();
		dispatch_group(3, 1'b0);
		cycle();
		put_cmp(0, issued[5], 1'b0, 32'h0);
		put_cmp(1, issued[4], 1'b0, 32'h0);
		put_cmp(2, issued[3], 1'b0, 32'h0);
		cycle();
		put_cmp(0, issued[0], 1'b0, 32'h0);
		put_cmp(1, issued[1], 1'b1, REDIRECT_TARGET);
		put_cmp(2, issued[2], 1'b0, 32'h0);
		cycle();
		cycle();
		check("flush after redirect", 32'(flush), 32'd1);
		check("retired up to redirect", 32'(retired - base), 32'd2);
		issued.delete();
		dispatch_group(2, 1'b0);
		check("first index after flush", 32'(disp_index[0]), 32'd0);
		cycle();
		complete_issued();
		drain();
		check("retired over redirect test", 32'(retired - base), 32'd4);
		check("flush pulses", 32'(flush_seen - flush_base), 32'd1);
	endtask

	task automatic test_random_order();
		int nc;
		int nd;
		int p;

		issued.delete();
		repeat (RAND_STEPS) begin
			nc = int'(take_bits(2));
			if (nc > issued.size()) begin
				nc = issued.size();
			end
			for (int lane = 0; lane < nc; lane++) begin
				p = int'(take_bits(4)) % issued.size();
				put_cmp(lane, issued[p], 1'b0, 32'h0);
				issued.delete(p);
			end
			nd = int'(take_bits(2));
			if (nd > credits) begin
				nd = credits;
			end
			dispatch_group(nd, 1'b1);
			cycle();
		end
		complete_issued();
		drain();
		check("credits after random test", 32'(credits), 32'(rob_pkg::ROB_DEPTH));
	endtask

	initial begin
		lfsr = 16'd29;
		errors = 0;
		checks = 0;
		retired = 0;
		flush_seen = 0;
		seq = 0;
		apply_reset();
		test_in_order();
		test_credits();
		test_freed_tags();
		test_redirect_flush();
		test_random_order();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
rtl/rob_pkg.sv
rtl/uop_pkg.sv
rtl/rob_control.sv
rtl/rob_entry_store.sv
rtl/retire_scan.sv
rtl/arch_map.sv
rtl/rob_top.sv
bench/rob_tb.sv

//--- rtl/arch_map.sv
`timescale 1ns/100ps
`default_nettype none

module arch_map (
	input  wire logic clock,
	input  wire logic arst_n,
	input  wire logic [rob_pkg::LANES-1:0] ret_valid,
	input  wire uop_pkg::arch_reg_t [rob_pkg::LANES-1:0] ret_arch_reg,
	input  wire uop_pkg::phys_tag_t [rob_pkg::LANES-1:0] ret_phys_tag,
	output logic [rob_pkg::LANES-1:0] freed_valid,
	output uop_pkg::phys_tag_t [rob_pkg::LANES-1:0] freed_tag
);

	uop_pkg::phys_tag_t map_q [uop_pkg::ARCH_REGS];

	// a lane frees what its register held just before it, which may be
	// the tag written by an older lane of the same group.
	always_comb begin
		for (int i = 0; i < rob_pkg::LANES; i++) begin
			freed_valid[i] = ret_valid[i];
			freed_tag[i] = map_q[ret_arch_reg[i]];
			for (int j = 0; j < i; j++) begin
				if (ret_valid[j] && ret_arch_reg[j] == ret_arch_reg[i]) begin
					freed_tag[i] = ret_phys_tag[j];
				end
			end
		end
	end

	// lanes are applied oldest first so the youngest write to a
	// register is the one that stays.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int r = 0; r < uop_pkg::ARCH_REGS; r++) begin
				map_q[r] <= uop_pkg::phys_tag_t'(r);
			end
		end else begin
			for (int i = 0; i < rob_pkg::LANES; i++) begin
				if (ret_valid[i]) begin
					map_q[ret_arch_reg[i]] <= ret_phys_tag[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/retire_scan.sv
`timescale 1ns/100ps
`default_nettype none

module retire_scan (
	input  wire uop_pkg::entry_state_e [rob_pkg::LANES-1:0] head_state,
	input  wire logic [rob_pkg::LANES-1:0] head_redirect,
	input  wire uop_pkg::pc_t [rob_pkg::LANES-1:0] head_target,
	output rob_pkg::lane_count_t ret_count,
	output logic ret_redirect,
	output uop_pkg::pc_t redirect_pc
);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// head scan
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// the group is the run of DONE entries starting at the head.
	// a redirect entry closes the group, since everything behind it
	// belongs to the wrong path.
	always_comb begin : scan
		logic stop;

		stop = 1'b0;
		ret_count = '0;
		ret_redirect = 1'b0;
		redirect_pc = '0;
		for (int i = 0; i < rob_pkg::LANES; i++) begin
			if (!stop) begin
				if (head_state[i] == uop_pkg::DONE) begin
					ret_count = rob_pkg::lane_count_t'(i + 1);
					if (head_redirect[i]) begin
						ret_redirect = 1'b1;
						redirect_pc = head_target[i];
						stop = 1'b1;
					end
				end else begin
					// an entry still in flight blocks all younger ones.
					stop = 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/rob_control.sv
`timescale 1ns/100ps
`default_nettype none

module rob_control (
	input  wire logic clock,
	input  wire logic arst_n,
	input  wire logic [rob_pkg::LANES-1:0] disp_valid,
	input  wire rob_pkg::lane_count_t ret_count,
	input  wire logic ret_redirect,
	input  wire uop_pkg::pc_t scan_target,
	output rob_pkg::rob_index_t head,
	output rob_pkg::rob_index_t tail,
	output logic [rob_pkg::LANES-1:0] disp_write,
	output logic clear_all,
	output rob_pkg::lane_count_t credit_return,
	output logic flush,
	output uop_pkg::pc_t redirect_pc,
	output rob_pkg::ctrl_state_e state
);

	rob_pkg::credit_t occupancy;
	rob_pkg::lane_count_t disp_count;
	rob_pkg::ctrl_state_e state_next;

	always_comb begin
		disp_count = '0;
		for (int i = 0; i < rob_pkg::LANES; i++) begin
			disp_write[i] = disp_valid[i] && !ret_redirect;
			if (disp_write[i]) begin
				disp_count = disp_count + 1'b1;
			end
		end
	end

	assign clear_all = ret_redirect;
	assign credit_return = ret_count;
	assign flush = (state == rob_pkg::FLUSH);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pointers and occupancy
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			head <= '0;
			tail <= '0;
			occupancy <= '0;
		end else if (ret_redirect) begin
			// everything younger than the redirect is discarded.
			head <= '0;
			tail <= '0;
			occupancy <= '0;
		end else begin
			head <= head + rob_pkg::rob_index_t'(ret_count);
			tail <= tail + rob_pkg::rob_index_t'(disp_count);
			occupancy <= occupancy - rob_pkg::credit_t'(ret_count)
				+ rob_pkg::credit_t'(disp_count);
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// flush sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_comb begin
		state_next = state;
		case (state)
			rob_pkg::RUN: begin
				if (ret_redirect) begin
					state_next = rob_pkg::FLUSH;
				end
			end
			rob_pkg::FLUSH: begin
				state_next = rob_pkg::RUN;
			end
			default: begin
				state_next = rob_pkg::RUN;
			end
		endcase
	end

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= rob_pkg::RUN;
			redirect_pc <= '0;
		end else begin
			state <= state_next;
			// the target is held for the single FLUSH cycle.
			if (ret_redirect) begin
				redirect_pc <= scan_target;
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/rob_entry_store.sv
`timescale 1ns/100ps
`default_nettype none

module rob_entry_store (
	input  wire logic clock,
	input  wire logic arst_n,
	input  wire rob_pkg::rob_index_t tail,
	input  wire rob_pkg::rob_index_t head,
	input  wire logic [rob_pkg::LANES-1:0] disp_write,
	input  wire uop_pkg::arch_reg_t [rob_pkg::LANES-1:0] disp_arch_reg,
	input  wire uop_pkg::phys_tag_t [rob_pkg::LANES-1:0] disp_phys_tag,
	input  wire uop_pkg::pc_t [rob_pkg::LANES-1:0] disp_pc,
	input  wire logic [rob_pkg::LANES-1:0] cmp_valid,
	input  wire rob_pkg::rob_index_t [rob_pkg::LANES-1:0] cmp_index,
	input  wire logic [rob_pkg::LANES-1:0] cmp_redirect,
	input  wire uop_pkg::pc_t [rob_pkg::LANES-1:0] cmp_target,
	input  wire rob_pkg::lane_count_t ret_count,
	input  wire logic clear_all,
	output uop_pkg::entry_state_e [rob_pkg::LANES-1:0] head_state,
	output logic [rob_pkg::LANES-1:0] head_redirect,
	output uop_pkg::arch_reg_t [rob_pkg::LANES-1:0] head_arch_reg,
	output uop_pkg::phys_tag_t [rob_pkg::LANES-1:0] head_phys_tag,
	output uop_pkg::pc_t [rob_pkg::LANES-1:0] head_pc,
	output uop_pkg::pc_t [rob_pkg::LANES-1:0] head_target
);

	uop_pkg::entry_state_e state_q [rob_pkg::ROB_DEPTH];
	uop_pkg::arch_reg_t arch_reg_q [rob_pkg::ROB_DEPTH];
	uop_pkg::phys_tag_t phys_tag_q [rob_pkg::ROB_DEPTH];
	uop_pkg::pc_t pc_q [rob_pkg::ROB_DEPTH];
	logic redirect_q [rob_pkg::ROB_DEPTH];
	uop_pkg::pc_t target_q [rob_pkg::ROB_DEPTH];

	rob_pkg::rob_index_t head_idx [rob_pkg::LANES];
	rob_pkg::rob_index_t tail_idx [rob_pkg::LANES];

	always_comb begin
		for (int i = 0; i < rob_pkg::LANES; i++) begin
			head_idx[i] = head + rob_pkg::rob_index_t'(i);
			tail_idx[i] = tail + rob_pkg::rob_index_t'(i);
		end
	end

	// later loops take priority, so a dispatch into a slot freed
	// in the same cycle leaves it BUSY.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int e = 0; e < rob_pkg::ROB_DEPTH; e++) begin
				state_q[e] <= uop_pkg::EMPTY;
			end
		end else if (clear_all) begin
			for (int e = 0; e < rob_pkg::ROB_DEPTH; e++) begin
				state_q[e] <= uop_pkg::EMPTY;
			end
		end else begin
			for (int i = 0; i < rob_pkg::LANES; i++) begin
				if (rob_pkg::lane_count_t'(i) < ret_count) begin
					state_q[head_idx[i]] <= uop_pkg::EMPTY;
				end
			end
			for (int i = 0; i < rob_pkg::LANES; i++) begin
				if (cmp_valid[i]) begin
					state_q[cmp_index[i]] <= uop_pkg::DONE;
				end
			end
			for (int i = 0; i < rob_pkg::LANES; i++) begin
				if (disp_write[i]) begin
					state_q[tail_idx[i]] <= uop_pkg::BUSY;
				end
			end
		end
	end

	// payload fields are only read once the entry is DONE.
	always_ff @(posedge clock) begin
		for (int i = 0; i < rob_pkg::LANES; i++) begin
			if (disp_write[i]) begin
				arch_reg_q[tail_idx[i]] <= disp_arch_reg[i];
				phys_tag_q[tail_idx[i]] <= disp_phys_tag[i];
				pc_q[tail_idx[i]] <= disp_pc[i];
			end
			if (cmp_valid[i]) begin
				redirect_q[cmp_index[i]] <= cmp_redirect[i];
				target_q[cmp_index[i]] <= cmp_target[i];
			end
		end
	end

	always_comb begin
		for (int i = 0; i < rob_pkg::LANES; i++) begin
			head_state[i] = state_q[head_idx[i]];
			head_redirect[i] = redirect_q[head_idx[i]];
			head_arch_reg[i] = arch_reg_q[head_idx[i]];
			head_phys_tag[i] = phys_tag_q[head_idx[i]];
			head_pc[i] = pc_q[head_idx[i]];
			head_target[i] = target_q[head_idx[i]];
		end
	end

endmodule

`default_nettype wire

//--- rtl/rob_pkg.sv
`default_nettype none

package rob_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// buffer geometry
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// number of reorder buffer entries.
	localparam int ROB_DEPTH = 16;

	// micro-ops dispatched, completed and retired per cycle.
	localparam int LANES = 3;

	localparam int INDEX_W = $clog2(ROB_DEPTH);
	localparam int LANE_COUNT_W = $clog2(LANES + 1);

	// occupancy runs from 0 to ROB_DEPTH inclusive.
	localparam int CREDIT_W = $clog2(ROB_DEPTH + 1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [INDEX_W-1:0] rob_index_t;
	typedef logic [LANE_COUNT_W-1:0] lane_count_t;
	typedef logic [CREDIT_W-1:0] credit_t;

	// the flush state lasts one cycle after a retiring redirect.
	typedef enum logic {
		RUN,
		FLUSH
	} ctrl_state_e;

endpackage

`default_nettype wire

//--- rtl/rob_top.sv
`timescale 1ns/100ps
`default_nettype none

module rob_top (
	input  wire logic clock,
	input  wire logic arst_n,

	input  wire logic [rob_pkg::LANES-1:0] disp_valid,
	input  wire uop_pkg::arch_reg_t [rob_pkg::LANES-1:0] disp_arch_reg,
	input  wire uop_pkg::phys_tag_t [rob_pkg::LANES-1:0] disp_phys_tag,
	input  wire uop_pkg::pc_t [rob_pkg::LANES-1:0] disp_pc,
	output rob_pkg::rob_index_t [rob_pkg::LANES-1:0] disp_index,

	input  wire logic [rob_pkg::LANES-1:0] cmp_valid,
	input  wire rob_pkg::rob_index_t [rob_pkg::LANES-1:0] cmp_index,
	input  wire logic [rob_pkg::LANES-1:0] cmp_redirect,
	input  wire uop_pkg::pc_t [rob_pkg::LANES-1:0] cmp_target,

	output logic [rob_pkg::LANES-1:0] ret_valid,
	output uop_pkg::arch_reg_t [rob_pkg::LANES-1:0] ret_arch_reg,
	output uop_pkg::phys_tag_t [rob_pkg::LANES-1:0] ret_phys_tag,
	output uop_pkg::pc_t [rob_pkg::LANES-1:0] ret_pc,
	output logic [rob_pkg::LANES-1:0] freed_valid,
	output uop_pkg::phys_tag_t [rob_pkg::LANES-1:0] freed_tag,

	output rob_pkg::lane_count_t credit_return,
	output logic flush,
	output uop_pkg::pc_t redirect_pc
);

	rob_pkg::rob_index_t head;
	rob_pkg::rob_index_t tail;
	logic [rob_pkg::LANES-1:0] disp_write;
	logic clear_all;
	rob_pkg::lane_count_t ret_count;
	logic ret_redirect;
	uop_pkg::pc_t scan_target;
	uop_pkg::entry_state_e [rob_pkg::LANES-1:0] head_state;
	logic [rob_pkg::LANES-1:0] head_redirect;
	uop_pkg::pc_t [rob_pkg::LANES-1:0] head_target;

	always_comb begin
		for (int i = 0; i < rob_pkg::LANES; i++) begin
			disp_index[i] = tail + rob_pkg::rob_index_t'(i);
			ret_valid[i] = (ret_count > rob_pkg::lane_count_t'(i));
		end
	end

	rob_control u_control (
		.clock(clock),
		.arst_n(arst_n),
		.disp_valid(disp_valid),
		.ret_count(ret_count),
		.ret_redirect(ret_redirect),
		.scan_target(scan_target),
		.head(head),
		.tail(tail),
		.disp_write(disp_write),
		.clear_all(clear_all),
		.credit_return(credit_return),
		.flush(flush),
		.redirect_pc(redirect_pc),
		.state()
	);

	rob_entry_store u_store (
		.clock(clock),
		.arst_n(arst_n),
		.tail(tail),
		.head(head),
		.disp_write(disp_write),
		.disp_arch_reg(disp_arch_reg),
		.disp_phys_tag(disp_phys_tag),
		.disp_pc(disp_pc),
		.cmp_valid(cmp_valid),
		.cmp_index(cmp_index),
		.cmp_redirect(cmp_redirect),
		.cmp_target(cmp_target),
		.ret_count(ret_count),
		.clear_all(clear_all),
		.head_state(head_state),
		.head_redirect(head_redirect),
		.head_arch_reg(ret_arch_reg),
		.head_phys_tag(ret_phys_tag),
		.head_pc(ret_pc),
		.head_target(head_target)
	);

	retire_scan u_scan (
		.head_state(head_state),
		.head_redirect(head_redirect),
		.head_target(head_target),
		.ret_count(ret_count),
		.ret_redirect(ret_redirect),
		.redirect_pc(scan_target)
	);

	arch_map u_map (
		.clock(clock),
		.arst_n(arst_n),
		.ret_valid(ret_valid),
		.ret_arch_reg(ret_arch_reg),
		.ret_phys_tag(ret_phys_tag),
		.freed_valid(freed_valid),
		.freed_tag(freed_tag)
	);

endmodule

`default_nettype wire

//--- rtl/uop_pkg.sv
`default_nettype none

package uop_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// micro-op fields
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// architectural register file size.
	localparam int ARCH_REGS = 32;
	localparam int ARCH_REG_W = $clog2(ARCH_REGS);

	// physical tags cover twice the architectural registers.
	localparam int PHYS_TAG_W = ARCH_REG_W + 1;

	localparam int PC_W = 32;

	typedef logic [ARCH_REG_W-1:0] arch_reg_t;
	typedef logic [PHYS_TAG_W-1:0] phys_tag_t;
	typedef logic [PC_W-1:0] pc_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// entry life cycle
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// an entry is BUSY from dispatch until its completion arrives,
	// then DONE until it retires or is flushed.
	typedef enum logic [1:0] {
		EMPTY,
		BUSY,
		DONE
	} entry_state_e;

endpackage

`default_nettype wire
